//--- files.f
rtl/memPkg.sv
rtl/byteRam.sv
rtl/memoryController.sv
rtl/dataAccessUnit.sv
rtl/loadStoreBuffer.sv
rtl/memSubsystem.sv
testbench/memSubsystemTb.sv

//--- rtl/byteRam.sv
`timescale 1ns/1ps
`default_nettype none

module byteRam (
    input  wire                            clk,
    input  wire [memPkg::addrWidth-1:0]    addr,
    input  wire                            we,
    input  wire [7:0]                      wdata,
    output logic [7:0]                     rdata
);
    import memPkg::*;

    logic [7:0]             mem [2 ** ramAddrBits];
    logic [ramAddrBits-1:0] index;

    // Upper address bits alias onto the same 4 KiB
    assign index = addr[ramAddrBits-1:0];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[index] <= wdata;
        end
        rdata <= mem[index];
    end

endmodule

`default_nettype wire

//--- rtl/dataAccessUnit.sv
`timescale 1ns/1ps
`default_nettype none

module dataAccessUnit (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            issueValid,
    input  wire memPkg::busReq_t           issueReq,
    input  wire [memPkg::tagWidth-1:0]     issueTag,
    input  wire                            dataWait,
    input  wire                            dataDone,
    input  wire [memPkg::dataWidth-1:0]    dataRdata,
    output logic                           accept,
    output logic                           memEn,
    output memPkg::busReq_t                memReq,
    output logic                           done,
    output logic [memPkg::dataWidth-1:0]   doneData,
    output logic [memPkg::tagWidth-1:0]    doneTag
);
    import memPkg::*;

    logic                occupied;
    logic                armed;
    busReq_t             heldReq;
    logic [tagWidth-1:0] heldTag;

    assign accept = !occupied;
    assign memReq = heldReq;

    // The request goes out one cycle after it lands here
    assign memEn = occupied && armed && !dataWait;

    always_ff @(posedge clk) begin
        if (rst) begin
            occupied <= 1'b0;
            armed    <= 1'b0;
            done     <= 1'b0;
        end else begin
            done <= dataDone;
            if (dataDone) begin
                occupied <= 1'b0;
                armed    <= 1'b0;
            end else begin
                armed <= occupied;
                if (accept && issueValid) begin
                    occupied <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && issueValid) begin
            heldReq <= issueReq;
            heldTag <= issueTag;
        end
        if (dataDone) begin
            doneData <= dataRdata;
            doneTag  <= heldTag;
        end
    end

endmodule

`default_nettype wire

//--- rtl/loadStoreBuffer.sv
`timescale 1ns/1ps
`default_nettype none

module loadStoreBuffer (
    input  wire                            clk,
    input  wire                            rst,
    input  wire memPkg::memReq_t           req,
    input  wire                            reqValid,
    input  wire                            accept,
    input  wire                            done,
    input  wire [memPkg::dataWidth-1:0]    doneData,
    input  wire [memPkg::tagWidth-1:0]     doneTag,
    output logic                           reqReady,
    output memPkg::memResp_t               resp,
    output logic                           respValid,
    output logic                           issueValid,
    output memPkg::busReq_t                issueReq,
    output logic [memPkg::tagWidth-1:0]    issueTag
);
    import memPkg::*;

    memReq_t               entries [lsbDepth];
    memReq_t               headReq;
    logic [lsbPtrBits-1:0] headPtr;
    logic [lsbPtrBits-1:0] tailPtr;
    logic [lsbPtrBits:0]   count;
    logic                  headIssued;
    logic                  push;
    logic                  pop;
    logic [dataWidth-1:0]  loadValue;

    assign headReq  = entries[headPtr];
    assign reqReady = count != (lsbPtrBits + 1)'(lsbDepth);
    assign push     = reqValid && reqReady;
    assign pop      = done;

    // The head stays in place after issue so its flags are at hand when the result returns
    assign issueValid = (count != '0) && !headIssued;
    assign issueTag   = headReq.tag;
    assign issueReq   = '{
        isStore: headReq.isStore,
        len:     headReq.len,
        addr:    headReq.addr,
        data:    headReq.data
    };

    always_comb begin
        case (headReq.len)
            lenByte: begin
                if (headReq.isSigned) begin
                    loadValue = {{(dataWidth - 8){doneData[7]}}, doneData[7:0]};
                end else begin
                    loadValue = {{(dataWidth - 8){1'b0}}, doneData[7:0]};
                end
            end
            lenHalf: begin
                if (headReq.isSigned) begin
                    loadValue = {{(dataWidth - 16){doneData[15]}}, doneData[15:0]};
                end else begin
                    loadValue = {{(dataWidth - 16){1'b0}}, doneData[15:0]};
                end
            end
            default: loadValue = doneData;
        endcase
    end

    assign respValid = done;
    assign resp      = '{
        isStore: headReq.isStore,
        data:    headReq.isStore ? '0 : loadValue,
        tag:     doneTag
    };

    always_ff @(posedge clk) begin
        if (rst) begin
            headPtr    <= '0;
            tailPtr    <= '0;
            count      <= '0;
            headIssued <= 1'b0;
        end else begin
            if (push) begin
                tailPtr <= tailPtr + 1'b1;
            end
            if (pop) begin
                headPtr    <= headPtr + 1'b1;
                headIssued <= 1'b0;
            end else if (accept && issueValid) begin
                headIssued <= 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entries[tailPtr] <= req;
        end
    end

endmodule

`default_nettype wire

//--- rtl/memPkg.sv
`default_nettype none

package memPkg;

    localparam int addrWidth   = 32;
    localparam int dataWidth   = 32;
    localparam int tagWidth    = 4;
    localparam int ramAddrBits = 12;
    localparam int lsbDepth    = 4;
    localparam int lsbPtrBits  = $clog2(lsbDepth);

    typedef enum logic [1:0] {
        lenByte = 2'd0,
        lenHalf = 2'd1,
        lenWord = 2'd2
    } accessLen_t;

    // One request as the core hands it over
    typedef struct packed {
        logic                 isStore;
        logic                 isSigned;
        accessLen_t           len;
        logic [addrWidth-1:0] addr;
        logic [dataWidth-1:0] data;
        logic [tagWidth-1:0]  tag;
    } memReq_t;

    // Data is the extended load value, zero for stores
    typedef struct packed {
        logic                 isStore;
        logic [dataWidth-1:0] data;
        logic [tagWidth-1:0]  tag;
    } memResp_t;

    // What the controller sees of a data request
    typedef struct packed {
        logic                 isStore;
        accessLen_t           len;
        logic [addrWidth-1:0] addr;
        logic [dataWidth-1:0] data;
    } busReq_t;

endpackage

`default_nettype wire

//--- rtl/memSubsystem.sv
`timescale 1ns/1ps
`default_nettype none

module memSubsystem (
    input  wire                            clk,
    input  wire                            rst,
    input  wire memPkg::memReq_t           req,
    input  wire                            reqValid,
    input  wire                            fetchEn,
    input  wire [memPkg::addrWidth-1:0]    fetchAddr,
    output logic                           reqReady,
    output memPkg::memResp_t               resp,
    output logic                           respValid,
    output logic                           fetchDone,
    output logic [memPkg::dataWidth-1:0]   fetchWord
);
    import memPkg::*;

    logic                 accept;
    logic                 issueValid;
    busReq_t              issueReq;
    logic [tagWidth-1:0]  issueTag;
    logic                 done;
    logic [dataWidth-1:0] doneData;
    logic [tagWidth-1:0]  doneTag;
    logic                 memEn;
    busReq_t              memReq;
    logic                 dataWait;
    logic                 dataDone;
    logic [dataWidth-1:0] dataRdata;
    logic [addrWidth-1:0] ramAddr;
    logic                 ramWe;
    logic [7:0]           ramWdata;
    logic [7:0]           ramRdata;

    loadStoreBuffer lsb (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .reqValid   (reqValid),
        .accept     (accept),
        .done       (done),
        .doneData   (doneData),
        .doneTag    (doneTag),
        .reqReady   (reqReady),
        .resp       (resp),
        .respValid  (respValid),
        .issueValid (issueValid),
        .issueReq   (issueReq),
        .issueTag   (issueTag)
    );

    dataAccessUnit dau (
        .clk        (clk),
        .rst        (rst),
        .issueValid (issueValid),
        .issueReq   (issueReq),
        .issueTag   (issueTag),
        .dataWait   (dataWait),
        .dataDone   (dataDone),
        .dataRdata  (dataRdata),
        .accept     (accept),
        .memEn      (memEn),
        .memReq     (memReq),
        .done       (done),
        .doneData   (doneData),
        .doneTag    (doneTag)
    );

    // The fetch port holds its request until fetchDone, so fetchWait is not needed here
    memoryController mc (
        .clk        (clk),
        .rst        (rst),
        .memEn      (memEn),
        .memReq     (memReq),
        .fetchEn    (fetchEn),
        .fetchAddr  (fetchAddr),
        .ramRdata   (ramRdata),
        .dataWait   (dataWait),
        .fetchWait  (),
        .dataDone   (dataDone),
        .dataRdata  (dataRdata),
        .fetchDone  (fetchDone),
        .fetchWord  (fetchWord),
        .ramAddr    (ramAddr),
        .ramWe      (ramWe),
        .ramWdata   (ramWdata)
    );

    byteRam ram (
        .clk   (clk),
        .addr  (ramAddr),
        .we    (ramWe),
        .wdata (ramWdata),
        .rdata (ramRdata)
    );

endmodule

`default_nettype wire

//--- rtl/memoryController.sv
`timescale 1ns/1ps
`default_nettype none

module memoryController (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            memEn,
    input  wire memPkg::busReq_t           memReq,
    input  wire                            fetchEn,
    input  wire [memPkg::addrWidth-1:0]    fetchAddr,
    input  wire [7:0]                      ramRdata,
    output logic                           dataWait,
    output logic                           fetchWait,
    output logic                           dataDone,
    output logic [memPkg::dataWidth-1:0]   dataRdata,
    output logic                           fetchDone,
    output logic [memPkg::dataWidth-1:0]   fetchWord,
    output logic [memPkg::addrWidth-1:0]   ramAddr,
    output logic                           ramWe,
    output logic [7:0]                     ramWdata
);
    import memPkg::*;

    typedef enum logic [1:0] {
        stIdle,
        stWrite,
        stRead
    } ctrlState_t;

    ctrlState_t           state;
    logic                 ownerFetch;
    logic [2:0]           cnt;
    logic [2:0]           nBytes;
    logic [addrWidth-1:0] baseAddr;
    logic [dataWidth-1:0] wordBuf;
    logic [1:0]           rdIdx;
    logic                 lastCycle;

    function automatic logic [2:0] byteCount(accessLen_t len);
        case (len)
            lenByte: byteCount = 3'd1;
            lenHalf: byteCount = 3'd2;
            default: byteCount = 3'd4;
        endcase
    endfunction

    assign dataWait  = state != stIdle;
    assign fetchWait = state != stIdle;

    // Writes finish once every byte is out, reads one cycle later for the RAM latency
    assign lastCycle = (state == stWrite && cnt == nBytes) ||
                       (state == stRead && cnt == nBytes + 3'd1);
    assign dataDone  = lastCycle && !ownerFetch;
    assign fetchDone = lastCycle && ownerFetch;

    // Holds store data during a write and the assembled bytes during a read
    assign dataRdata = wordBuf;
    assign fetchWord = wordBuf;

    // Byte cnt-1 arrives from the RAM while address cnt is out
    assign rdIdx = cnt[1:0] - 2'd1;

    // Byte 0 goes to the RAM on the grant cycle itself
    always_comb begin
        ramAddr  = baseAddr + addrWidth'(cnt);
        ramWe    = 1'b0;
        ramWdata = wordBuf[8 * cnt[1:0] +: 8];
        if (state == stIdle) begin
            ramAddr  = memEn ? memReq.addr : fetchAddr;
            ramWe    = memEn && memReq.isStore;
            ramWdata = memReq.data[7:0];
        end else if (state == stWrite) begin
            ramWe = cnt < nBytes;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= stIdle;
            ownerFetch <= 1'b0;
            cnt        <= '0;
            nBytes     <= '0;
        end else begin
            case (state)
                stIdle: begin
                    cnt <= 3'd1;
                    // The data client wins when both ask
                    if (memEn) begin
                        ownerFetch <= 1'b0;
                        nBytes     <= byteCount(memReq.len);
                        state      <= memReq.isStore ? stWrite : stRead;
                    end else if (fetchEn) begin
                        ownerFetch <= 1'b1;
                        nBytes     <= 3'd4;
                        state      <= stRead;
                    end
                end
                stWrite: begin
                    if (cnt == nBytes) begin
                        state <= stIdle;
                    end else begin
                        cnt <= cnt + 3'd1;
                    end
                end
                stRead: begin
                    if (cnt == nBytes + 3'd1) begin
                        state <= stIdle;
                    end else begin
                        cnt <= cnt + 3'd1;
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == stIdle) begin
            if (memEn) begin
                baseAddr <= memReq.addr;
                wordBuf  <= memReq.data;
            end else if (fetchEn) begin
                baseAddr <= fetchAddr;
            end
        end else if (state == stRead && cnt <= nBytes) begin
            wordBuf[8 * rdIdx +: 8] <= ramRdata;
        end
    end

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/1ps -f files.f \
    --top-module memSubsystemTb -Mdir obj_dir -o memSubsystemTb &&
./obj_dir/memSubsystemTb ||
{ echo "simulation did not complete cleanly" >&2; exit 1; }

//--- testbench/memSubsystemTb.sv
`timescale 1ns/1ps
`default_nettype none

module memSubsystemTb;
    import memPkg::*;

    logic                 clk = 1'b0;
    logic                 rst;
    memReq_t              req;
    logic                 reqValid;
    logic                 fetchEn;
    logic [addrWidth-1:0] fetchAddr;
    logic                 reqReady;
    memResp_t             resp;
    logic                 respValid;
    logic                 fetchDone;
    logic [dataWidth-1:0] fetchWord;

    logic [7:0]           model [2 ** ramAddrBits];
    memResp_t             expQ [$];
    logic [tagWidth-1:0]  tagCnt = '0;
    logic                 sawFull;

    memSubsystem DUT (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .reqValid  (reqValid),
        .fetchEn   (fetchEn),
        .fetchAddr (fetchAddr),
        .reqReady  (reqReady),
        .resp      (resp),
        .respValid (respValid),
        .fetchDone (fetchDone),
        .fetchWord (fetchWord)
    );

    always #20 clk = ~clk;

    task automatic abortRun(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "stopped at the first failed check");
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abortRun($sformatf("mismatch %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic compareResp(input memResp_t got, input memResp_t exp);
        if (got.tag !== exp.tag) begin
            abortRun($sformatf("mismatch resp.tag: got 0x%h expected 0x%h", got.tag, exp.tag));
        end
        if (got.isStore !== exp.isStore) begin
            abortRun($sformatf("mismatch resp.isStore (tag 0x%h): got 0x%h expected 0x%h",
                               exp.tag, got.isStore, exp.isStore));
        end
        if (got.data !== exp.data) begin
            abortRun($sformatf("mismatch resp.data (tag 0x%h): got 0x%h expected 0x%h",
                               exp.tag, got.data, exp.data));
        end
    endtask

    task automatic compareFetch(input logic [dataWidth-1:0] got, input logic [dataWidth-1:0] exp);
        if (got !== exp) begin
            abortRun($sformatf("mismatch fetchWord: got 0x%h expected 0x%h", got, exp));
        end
    endtask

    // Initial fill byte, hashed from the whole address
    function automatic logic [7:0] fillByte(input logic [addrWidth-1:0] addr);
        logic [31:0] h;
        h = addr * 32'h0100_0193 + 32'h811C_9DC5;
        return h[7:0] ^ h[15:8] ^ h[23:16] ^ h[31:24];
    endfunction

    function automatic logic [tagWidth-1:0] nextTag();
        nextTag = tagCnt;
        tagCnt  = tagCnt + tagWidth'(1);
    endfunction

    function automatic memReq_t makeReq(input logic isStore, input logic isSigned,
                                        input accessLen_t len, input logic [addrWidth-1:0] addr,
                                        input logic [dataWidth-1:0] data,
                                        input logic [tagWidth-1:0] tag);
        memReq_t r;
        r.isStore  = isStore;
        r.isSigned = isSigned;
        r.len      = len;
        r.addr     = addr;
        r.data     = data;
        r.tag      = tag;
        return r;
    endfunction

    function automatic void applyStore(input memReq_t r);
        int k;
        int n;
        n = (r.len == lenByte) ? 1 : (r.len == lenHalf) ? 2 : 4;
        for (k = 0; k < n; k++) begin
            model[r.addr[ramAddrBits-1:0] + ramAddrBits'(k)] = r.data[8 * k +: 8];
        end
    endfunction

    function automatic logic [dataWidth-1:0] refLoad(input memReq_t r);
        logic [ramAddrBits-1:0] a;
        logic [dataWidth-1:0]   value;
        a     = r.addr[ramAddrBits-1:0];
        value = {model[a + 12'd3], model[a + 12'd2], model[a + 12'd1], model[a]};
        // Mask to the accessed bytes, then fill upward from their top bit when signed
        if (r.len == lenByte) begin
            value = value & 32'h0000_00FF;
            if (r.isSigned && value[7])
                value = value | 32'hFFFF_FF00;
        end else if (r.len == lenHalf) begin
            value = value & 32'h0000_FFFF;
            if (r.isSigned && value[15])
                value = value | 32'hFFFF_0000;
        end
        return value;
    endfunction

    function automatic logic [dataWidth-1:0] refFetch(input logic [addrWidth-1:0] addr);
        logic [dataWidth-1:0] w;
        int                   k;
        for (k = 0; k < 4; k++) begin
            w[8 * k +: 8] = model[addr[ramAddrBits-1:0] + ramAddrBits'(k)];
        end
        return w;
    endfunction

    // Data requests complete in order, so the model advances at the handshake
    task automatic issueRequest(input memReq_t r);
        memResp_t expResp;
        int       waited;
        waited   = 0;
        req      = r;
        reqValid = 1'b1;
        while (!reqReady) begin
            sawFull = 1'b1;
            @(posedge clk);
            #2;
            waited++;
            if (waited >= 200)
                abortRun("reqReady stayed low for 200 cycles");
        end
        expResp.isStore = r.isStore;
        expResp.tag     = r.tag;
        expResp.data    = r.isStore ? '0 : refLoad(r);
        if (r.isStore)
            applyStore(r);
        expQ.push_back(expResp);
        @(posedge clk);
        #2;
        reqValid = 1'b0;
    endtask

    task automatic runFetch(input logic [addrWidth-1:0] addr);
        logic [dataWidth-1:0] expWord;
        int                   waited;
        expWord   = refFetch(addr);
        waited    = 0;
        fetchAddr = addr;
        fetchEn   = 1'b1;
        @(negedge clk);
        while (!fetchDone) begin
            @(negedge clk);
            waited++;
            if (waited >= 200)
                abortRun("fetchDone did not arrive within 200 cycles");
        end
        compareFetch(fetchWord, expWord);
        @(posedge clk);
        #2;
        fetchEn = 1'b0;
    endtask

    task automatic drainResponses();
        int waited;
        waited = 0;
        while (expQ.size() != 0) begin
            @(posedge clk);
            #2;
            waited++;
            if (waited >= 200)
                abortRun("responses still missing after 200 cycles");
        end
    endtask

    always @(negedge clk) begin
        if (!rst && respValid) begin
            if (expQ.size() == 0) begin
                abortRun("a response arrived with no request outstanding");
            end else begin
                compareResp(resp, expQ.pop_front());
            end
        end
    end

    initial begin
        logic [addrWidth-1:0] a;
        accessLen_t           len;
        int                   i;
        void'($urandom(37297));
        rst       = 1'b1;
        req       = '0;
        reqValid  = 1'b0;
        fetchEn   = 1'b0;
        fetchAddr = '0;
        sawFull   = 1'b0;
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;
        @(negedge clk);
        checkFlag("reqReady", reqReady, 1'b1);
        checkFlag("respValid", respValid, 1'b0);
        checkFlag("fetchDone", fetchDone, 1'b0);
        @(posedge clk);
        #2;

        // Data region 0x000-0x0FF and fetch region 0x100-0x1FF start from known bytes
        for (a = 0; a < 32'h200; a += 4) begin
            issueRequest(makeReq(1'b1, 1'b0, lenWord, a,
                                 {fillByte(a + 3), fillByte(a + 2), fillByte(a + 1), fillByte(a)},
                                 nextTag()));
        end
        drainResponses();

        issueRequest(makeReq(1'b1, 1'b0, lenWord, 32'h40, 32'hA1B2_C3D4, nextTag()));
        issueRequest(makeReq(1'b1, 1'b0, lenHalf, 32'h44, 32'h5A5A_8E7F, nextTag()));
        issueRequest(makeReq(1'b1, 1'b0, lenByte, 32'h46, 32'hDEAD_BE95, nextTag()));
        for (a = 32'h40; a < 32'h48; a++) begin
            issueRequest(makeReq(1'b0, 1'b0, lenByte, a, '0, nextTag()));
            if (a[0] == 1'b0)
                issueRequest(makeReq(1'b0, 1'b0, lenHalf, a, '0, nextTag()));
            if (a[1:0] == 2'b00)
                issueRequest(makeReq(1'b0, 1'b0, lenWord, a, '0, nextTag()));
        end
        drainResponses();

        issueRequest(makeReq(1'b1, 1'b0, lenWord, 32'h80, 32'h857F_9CF3, nextTag()));
        for (a = 32'h80; a < 32'h84; a++) begin
            issueRequest(makeReq(1'b0, 1'b1, lenByte, a, '0, nextTag()));
            issueRequest(makeReq(1'b0, 1'b0, lenByte, a, '0, nextTag()));
            if (a[0] == 1'b0) begin
                issueRequest(makeReq(1'b0, 1'b1, lenHalf, a, '0, nextTag()));
                issueRequest(makeReq(1'b0, 1'b0, lenHalf, a, '0, nextTag()));
            end
        end
        drainResponses();

        sawFull = 1'b0;
        for (i = 0; i < 10; i++) begin
            a = 32'hC0 + 32'(4 * (i / 2));
            issueRequest(makeReq((i % 2) == 0, 1'b0, lenWord, a, $urandom, nextTag()));
        end
        drainResponses();
        if (!sawFull)
            abortRun("reqReady never dropped with more requests queued than the buffer holds");

        // Fetches go to addresses that the data traffic running alongside never touches
        issueRequest(makeReq(1'b1, 1'b0, lenWord, 32'h120, 32'h1357_9BDF, nextTag()));
        drainResponses();
        fork
            begin
                for (i = 0; i < 6; i++) begin
                    a = 32'h10 + 32'(4 * (i / 2));
                    issueRequest(makeReq((i % 2) == 0, 1'b0, lenWord, a, $urandom, nextTag()));
                end
            end
            begin
                runFetch(32'h120);
                runFetch(32'h1F0);
            end
        join
        drainResponses();

        for (i = 0; i < 300; i++) begin
            len = accessLen_t'(2'($urandom % 3));
            a   = $urandom % 256;
            if (len == lenHalf)
                a[0] = 1'b0;
            else if (len == lenWord)
                a[1:0] = 2'b00;
            issueRequest(makeReq(1'($urandom % 2), 1'($urandom % 2), len, a, $urandom,
                                 tagWidth'($urandom)));
            if ($urandom % 8 == 0)
                runFetch(32'h100 + ($urandom % 64) * 4);
        end
        drainResponses();

        // With every response back the buffer is empty again
        @(negedge clk);
        checkFlag("reqReady", reqReady, 1'b1);
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire
